// ==== mac_tx.f ====
+incdir+verif
design/mac_tx_pkg.sv
design/crc32_engine.sv
design/payload_fifo.sv
design/mac_tx_framer.sv
design/mac_tx_top.sv
verif/mac_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the MAC transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module mac_tx_tb -f mac_tx.f \
  --Mdir "$build_dir" -o mac_tx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/mac_tx_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Finished with errors" "$log_file"; then
  echo "Simulation failed, see $log_file"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation passed"
exit 0

// ==== verif/mac_tx_tb_util.svh ====
`ifndef MAC_TX_TB_UTIL_SVH
`define MAC_TX_TB_UTIL_SVH

logic [31:0] lfsr_state = 32'd84297;

// Galois form with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [63:0] draw_bits(input int n);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v          = {v[62:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return v;
endfunction

// Bit-serial reflected CRC-32 before the final inversion
function automatic logic [31:0] crc32_model(input logic [7:0] bytes[$]);
  logic [31:0] r;
  logic        fb;
  r = 32'hffff_ffff;
  foreach (bytes[n]) begin
    for (int b = 0; b < 8; b++) begin
      fb = r[0] ^ bytes[n][b]; // LSB of each byte first
      r  = r >> 1;
      if (fb) r = r ^ 32'hedb8_8320;
    end
  end
  return r;
endfunction

// Whole frame as it should appear on the PHY
function automatic void build_frame(
  input  mac_tx_pkg::tx_meta_t  m,
  input  mac_tx_pkg::mac_addr_t src,
  input  logic [7:0]            pld[$],
  input  int                    min_pld,
  output logic [7:0]            frm[$]
);
  logic [7:0]  body[$]; // dst_mac through the last pad byte
  logic [31:0] fcs;
  frm.delete();
  for (int i = 0; i < 7; i++) frm.push_back(8'h55);
  frm.push_back(8'hd5);
  for (int i = 5; i >= 0; i--) body.push_back(m.dst_mac[i]);
  for (int i = 5; i >= 0; i--) body.push_back(src[i]);
  body.push_back(m.ethertype[15:8]);
  body.push_back(m.ethertype[7:0]);
  foreach (pld[i]) body.push_back(pld[i]);
  while (body.size() < 14 + min_pld) body.push_back(8'h00);
  fcs = ~crc32_model(body);
  foreach (body[i]) frm.push_back(body[i]);
  for (int i = 0; i < 4; i++) frm.push_back(fcs[8*i +: 8]);
endfunction

task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int idx);
  if (got !== exp) begin
    report_mismatch($sformatf("byte %0d is 0x%02h, expected 0x%02h", idx, got, exp));
  end
endtask

task automatic check_len(input mac_tx_pkg::length_t got, input mac_tx_pkg::length_t exp,
                         input string what);
  if (got !== exp) report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
endtask

task automatic check_meta(input mac_tx_pkg::mac_addr_t got_dst,
                          input mac_tx_pkg::mac_addr_t exp_dst,
                          input logic [15:0]           got_type,
                          input logic [15:0]           exp_type);
  if (got_dst !== exp_dst) begin
    report_mismatch($sformatf("dst_mac %h, expected %h", got_dst, exp_dst));
  end
  if (got_type !== exp_type) begin
    report_mismatch($sformatf("ethertype %h, expected %h", got_type, exp_type));
  end
endtask

task automatic check_cycle(input int got, input int exp, input string what);
  if (got != exp) report_mismatch($sformatf("%s at cycle %0d, expected %0d", what, got, exp));
endtask

`endif

// ==== verif/mac_tx_tb.sv ====
`timescale 1ns/1ps

module mac_tx_tb;

  localparam int MIN_PLD    = 46;
  localparam int IFG_LEN    = 12;
  localparam int NUM_FRAMES = 40;
  localparam int WAIT_LIMIT = 4000; // Longest frame plus gap is near 1550 cycles

  localparam mac_tx_pkg::mac_addr_t SRC_MAC = 48'h02_00_5e_10_20_30;

  logic                  clk;
  logic                  fsm_rst;
  logic                  pld_wr;
  logic [7:0]            pld_wdat;
  mac_tx_pkg::tx_meta_t  meta;
  logic                  rdy;
  logic                  acc;
  logic                  done;
  mac_tx_pkg::phy_byte_t phy;
  logic                  pld_full;

  int cyc        = 0; // Rising edges so far
  int done_cnt   = 0;
  int early_hits = 0; // Frames with rdy up while the gap ran

  logic [7:0]           exp_bytes[$];
  mac_tx_pkg::length_t  exp_lens[$];
  mac_tx_pkg::tx_meta_t exp_meta[$];
  int                   rdy_rise[$];

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "mac_tx_tb stopped at the first failure");
  endtask

  task automatic report_mismatch(input string msg);
    $display("error at %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  `include "mac_tx_tb_util.svh"

  mac_tx_top uut (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .src_mac  (SRC_MAC),
    .pld_wr   (pld_wr),
    .pld_wdat (pld_wdat),
    .meta     (meta),
    .rdy      (rdy),
    .acc      (acc),
    .done     (done),
    .phy      (phy),
    .pld_full (pld_full)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (done) done_cnt <= done_cnt + 1;
  end

  task automatic drive_frames();
    mac_tx_pkg::tx_meta_t m;
    logic [7:0]           pld[$];
    logic [7:0]           frm[$];
    logic                 early;
    int                   t;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      case (f)
        0 : m.length = 1;
        1 : m.length = MIN_PLD;
        2 : m.length = MIN_PLD + 1;
        3 : m.length = 1500;
        4 : m.length = 1; // Short frame right behind the longest one
        default : begin
          if (draw_bits(1) == 1) m.length = mac_tx_pkg::length_t'(1 + draw_bits(6));
          else m.length = mac_tx_pkg::length_t'(1 + draw_bits(11) % 1500);
        end
      endcase
      m.dst_mac   = mac_tx_pkg::mac_addr_t'(draw_bits(48));
      m.ethertype = 16'(draw_bits(16));
      early       = (f > 0) && (f == 4 || draw_bits(2) == 0);
      pld.delete();
      for (int i = 0; i < m.length; i++) pld.push_back(8'(draw_bits(8)));
      foreach (pld[i]) begin
        @(negedge clk);
        if (pld_full) report_failure("payload buffer full while writing a frame");
        pld_wr   = 1'b1;
        pld_wdat = pld[i];
      end
      @(negedge clk);
      pld_wr = 1'b0;
      build_frame(m, SRC_MAC, pld, MIN_PLD, frm);
      foreach (frm[i]) exp_bytes.push_back(frm[i]);
      exp_lens.push_back(mac_tx_pkg::length_t'(frm.size()));
      exp_meta.push_back(m);
      if (!early) begin
        t = 0;
        while (done_cnt < f) begin
          @(negedge clk);
          t++;
          if (t > WAIT_LIMIT) report_failure("timeout: previous frame never raised done");
        end
        repeat (int'(draw_bits(4))) @(negedge clk);
      end
      meta = m;
      rdy  = 1'b1;
      rdy_rise.push_back(cyc);
      t = 0;
      do begin
        @(negedge clk);
        t++;
        if (t > WAIT_LIMIT) report_failure("timeout: driver never saw acc for its frame");
      end while (!acc);
      rdy = 1'b0;
    end
  endtask

  task automatic check_frames();
    mac_tx_pkg::tx_meta_t m;
    logic [7:0]           got[$];
    int                   acc_cyc;
    int                   exp_acc;
    int                   last_done;
    int                   t;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      t = 0;
      do begin
        @(negedge clk);
        t++;
        if (phy.val) report_mismatch("phy.val high before the frame was accepted");
        if (done) report_mismatch("done high outside the cycle after a frame");
        if (t > WAIT_LIMIT) report_failure("timeout: acc never came for the next frame");
      end while (!acc);
      acc_cyc = cyc;
      exp_acc = rdy_rise.pop_front() + 1;
      // Capture waits until the gap has run out
      if (f > 0 && last_done + IFG_LEN + 1 > exp_acc) begin
        exp_acc = last_done + IFG_LEN + 1;
        early_hits++;
      end
      check_cycle(acc_cyc, exp_acc, "acc");
      t = 0;
      do begin
        @(negedge clk);
        t++;
        if (acc) report_mismatch("acc high for more than one cycle");
        if (t > WAIT_LIMIT) report_failure("timeout: phy.val never rose after acc");
      end while (!phy.val);
      check_cycle(cyc, acc_cyc + 2, "phy.val rise");
      got.delete();
      t = 0;
      while (phy.val) begin
        got.push_back(phy.dat);
        if (done) report_mismatch("done high while the frame is on the line");
        @(negedge clk);
        t++;
        if (t > WAIT_LIMIT) report_failure("timeout: phy.val never dropped");
      end
      last_done = cyc;
      if (!done) report_mismatch("done missing in the cycle after the last byte");
      m = exp_meta.pop_front();
      check_len(mac_tx_pkg::length_t'(got.size()), exp_lens.pop_front(), "frame length");
      check_meta({got[8], got[9], got[10], got[11], got[12], got[13]}, m.dst_mac,
                 {got[20], got[21]}, m.ethertype);
      foreach (got[i]) check_byte(got[i], exp_bytes.pop_front(), i);
    end
  endtask

  initial begin
    fsm_rst  = 1'b1;
    pld_wr   = 1'b0;
    pld_wdat = '0;
    meta     = '0;
    rdy      = 1'b0;
    repeat (10) @(negedge clk);
    fsm_rst = 1'b0;
    if (acc || done || phy.val) report_mismatch("outputs not idle after reset");
    fork
      drive_frames();
      check_frames();
    join
    repeat (IFG_LEN + 2) begin
      @(negedge clk);
      if (done || phy.val) report_mismatch("activity after the last frame");
    end
    if (early_hits == 0) begin
      report_failure("no frame had rdy high during the inter-frame gap");
    end
    else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule : mac_tx_tb

// ==== design/mac_tx_top.sv ====
`timescale 1ns/1ps

module mac_tx_top #(
  parameter int MIN_PLD    = 46,
  parameter int IFG_LEN    = 12,
  parameter int FIFO_DEPTH = 2048
)(
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  mac_tx_pkg::mac_addr_t src_mac,
  input  logic                  pld_wr,
  input  logic [7:0]            pld_wdat,
  input  mac_tx_pkg::tx_meta_t  meta,
  input  logic                  rdy,
  output logic                  acc,
  output logic                  done,
  output mac_tx_pkg::phy_byte_t phy,
  output logic                  pld_full
);

  logic        pld_req;
  logic [7:0]  pld_rdat;
  logic        crc_clr;
  logic        crc_en;
  logic [7:0]  crc_dat;
  logic [31:0] crc;

  payload_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) pld_fifo (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr      (pld_wr),
    .wdat    (pld_wdat),
    .rd      (pld_req),
    .rdat    (pld_rdat),
    .empty   (), // Only checked inside the FIFO
    .full    (pld_full)
  );

  mac_tx_framer #(
    .MIN_PLD (MIN_PLD),
    .IFG_LEN (IFG_LEN)
  ) framer (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .src_mac  (src_mac),
    .meta     (meta),
    .rdy      (rdy),
    .pld_rdat (pld_rdat),
    .crc      (crc),
    .acc      (acc),
    .done     (done),
    .pld_req  (pld_req),
    .crc_clr  (crc_clr),
    .crc_en   (crc_en),
    .crc_dat  (crc_dat),
    .phy      (phy)
  );

  crc32_engine crc_eng (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .crc_clr (crc_clr),
    .crc_en  (crc_en),
    .dat     (crc_dat),
    .crc     (crc)
  );

endmodule : mac_tx_top

// ==== design/mac_tx_framer.sv ====
`timescale 1ns/1ps

module mac_tx_framer #(
  parameter int MIN_PLD = 46,
  parameter int IFG_LEN = 12
)(
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  mac_tx_pkg::mac_addr_t src_mac,
  input  mac_tx_pkg::tx_meta_t  meta,
  input  logic                  rdy,
  input  logic [7:0]            pld_rdat,
  input  logic [31:0]           crc,
  output logic                  acc,
  output logic                  done,
  output logic                  pld_req,
  output logic                  crc_clr,
  output logic                  crc_en,
  output logic [7:0]            crc_dat,
  output mac_tx_pkg::phy_byte_t phy
);

  localparam int HDR_LEN = mac_tx_pkg::HDR_LEN;
  localparam int FCS_LEN = mac_tx_pkg::FCS_LEN;
  localparam int MAX_PLD = 1500; // No jumbo frames

  localparam logic [mac_tx_pkg::PREAMBLE_LEN-1:0][7:0] PREAMBLE =
    {{(mac_tx_pkg::PREAMBLE_LEN-1){8'h55}}, 8'hd5};

  typedef enum logic [2:0] {
    idle_s,
    hdr_s,
    pld_s,
    pad_s,
    fcs_s,
    gap_s
  } state_t;

  state_t state;

  logic [HDR_LEN-1:0][7:0]        hdr_sr;
  logic [$clog2(HDR_LEN)-1:0]     hdr_cnt;
  mac_tx_pkg::length_t            cur_len;
  mac_tx_pkg::length_t            tot_len;  // Length padded up to MIN_PLD
  mac_tx_pkg::length_t            byte_cnt; // Payload plus pad bytes sent
  mac_tx_pkg::length_t            req_cnt;
  logic [$clog2(FCS_LEN)-1:0]     fcs_cnt;
  logic [$clog2(IFG_LEN+1)-1:0]   gap_cnt;
  logic [FCS_LEN-1:0][7:0]        fcs_word;
  mac_tx_pkg::phy_byte_t          nxt;

  assign fcs_word = ~crc;
  assign crc_clr  = (state == idle_s);
  assign crc_dat  = nxt.dat;

  // Byte for the next PHY cycle, also fed to the CRC
  always_comb begin
    nxt    = '0;
    crc_en = 1'b0;
    case (state)
      hdr_s : begin
        if (!acc) begin
          nxt.val = 1'b1;
          nxt.dat = hdr_sr[HDR_LEN-1];
          crc_en  = (hdr_cnt >= mac_tx_pkg::PREAMBLE_LEN); // FCS starts at dst_mac
        end
      end
      pld_s : begin
        nxt.val = 1'b1;
        nxt.dat = pld_rdat;
        crc_en  = 1'b1;
      end
      pad_s : begin
        nxt.val = 1'b1; // Zero pad
        crc_en  = 1'b1;
      end
      fcs_s : begin
        nxt.val = 1'b1;
        nxt.dat = fcs_word[fcs_cnt]; // LSB first
      end
      default : ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= idle_s;
      acc      <= 1'b0;
      done     <= 1'b0;
      hdr_cnt  <= '0;
      byte_cnt <= '0;
      fcs_cnt  <= '0;
      gap_cnt  <= '0;
    end
    else begin
      done <= 1'b0;
      case (state)
        idle_s : begin
          if (rdy) begin
            acc     <= 1'b1;
            state   <= hdr_s;
            hdr_cnt <= '0;
            fcs_cnt <= '0;
            cur_len <= meta.length;
            tot_len <= (meta.length > MIN_PLD) ? meta.length
                                               : mac_tx_pkg::length_t'(MIN_PLD);
            hdr_sr  <= {PREAMBLE, meta.dst_mac, src_mac, meta.ethertype};
          end
        end
        hdr_s : begin
          if (acc) begin
            acc <= 1'b0; // Dead cycle after capture
          end
          else begin
            hdr_sr  <= {hdr_sr[HDR_LEN-2:0], 8'h00};
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt == HDR_LEN - 1) begin
              state    <= pld_s;
              byte_cnt <= '0;
            end
          end
        end
        pld_s : begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == cur_len - 1) begin
            state <= (byte_cnt == tot_len - 1) ? fcs_s : pad_s;
          end
        end
        pad_s : begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == tot_len - 1) state <= fcs_s;
        end
        fcs_s : begin
          fcs_cnt <= fcs_cnt + 1'b1;
          if (fcs_cnt == FCS_LEN - 1) begin
            state   <= gap_s;
            gap_cnt <= '0;
          end
        end
        gap_s : begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == 0) done <= 1'b1; // Line just went idle
          if (gap_cnt == IFG_LEN) state <= idle_s;
        end
        default : state <= idle_s;
      endcase
    end
  end

  // Payload request runs one cycle ahead of the FIFO's read latency
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pld_req <= 1'b0;
      req_cnt <= '0;
    end
    else if (state == hdr_s && !acc && hdr_cnt == HDR_LEN - 2) begin
      pld_req <= 1'b1;
      req_cnt <= '0;
    end
    else if (pld_req) begin
      req_cnt <= req_cnt + 1'b1;
      if (req_cnt == cur_len - 1) pld_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    phy.dat <= nxt.dat;
    if (fsm_rst) begin
      phy.val <= 1'b0;
    end
    else begin
      phy.val <= nxt.val;
    end
  end

  // No gaps once the preamble has started
  a_val_steady : assert property (
    @(posedge clk) disable iff (fsm_rst)
    phy.val && state != gap_s |=> phy.val
  ) else $error("mac_tx_framer: phy.val dropped inside a frame");

  a_len_range : assert property (
    @(posedge clk) disable iff (fsm_rst)
    $rose(acc) |-> (cur_len >= 1 && cur_len <= MAX_PLD)
  ) else $error("mac_tx_framer: captured length out of range");

endmodule : mac_tx_framer

// ==== design/payload_fifo.sv ====
`timescale 1ns/1ps

module payload_fifo #(
  parameter int FIFO_DEPTH = 2048
)(
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       wr,
  input  logic [7:0] wdat,
  input  logic       rd,
  output logic [7:0] rdat,
  output logic       empty,
  output logic       full
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [7:0] mem [FIFO_DEPTH];

  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
    end
    else if (wr) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr[AW-1:0]] <= wdat;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rd_ptr <= '0;
    end
    else if (rd) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Registered read port, byte valid the cycle after rd
  always_ff @(posedge clk) begin
    if (rd) begin
      rdat <= mem[rd_ptr[AW-1:0]];
    end
  end

  a_no_overflow : assert property (
    @(posedge clk) disable iff (fsm_rst)
    wr |-> !full
  ) else $error("payload_fifo: write while full");

  // Framer requests exactly length bytes, so the buffer must hold them all
  a_no_underflow : assert property (
    @(posedge clk) disable iff (fsm_rst)
    rd |-> !empty
  ) else $error("payload_fifo: read while empty");

endmodule : payload_fifo

// ==== design/crc32_engine.sv ====
`timescale 1ns/1ps

module crc32_engine (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        crc_clr,
  input  logic        crc_en,
  input  logic [7:0]  dat,
  output logic [31:0] crc
);

  localparam logic [31:0] POLY = 32'hedb8_8320; // Bit-reversed 0x04C11DB7

  // One byte folded in LSB first
  function automatic logic [31:0] fold_byte(
    input logic [31:0] cur,
    input logic [7:0]  din
  );
    logic [31:0] r;
    r = cur ^ {24'h0, din};
    for (int i = 0; i < 8; i++) begin
      if (r[0]) begin
        r = (r >> 1) ^ POLY;
      end
      else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst || crc_clr) begin
      crc <= mac_tx_pkg::CRC_RESIDUE_INIT;
    end
    else if (crc_en) begin
      crc <= fold_byte(crc, dat);
    end
  end

  // Framer must never clear in the middle of a fold
  a_clr_en_excl : assert property (
    @(posedge clk) disable iff (fsm_rst)
    !(crc_clr && crc_en)
  ) else $error("crc32_engine: crc_clr and crc_en high together");

endmodule : crc32_engine

// ==== design/mac_tx_pkg.sv ====
package mac_tx_pkg;

  // Frame layout in bytes
  localparam int PREAMBLE_LEN = 8;                 // Seven 0x55 plus the 0xD5 delimiter
  localparam int HDR_LEN      = PREAMBLE_LEN + 14; // Preamble, two addresses, ethertype
  localparam int FCS_LEN      = 4;

  localparam logic [31:0] CRC_RESIDUE_INIT = 32'hffff_ffff;

  // Byte 5 goes on the line first
  typedef logic [5:0][7:0] mac_addr_t;

  // Payload length, 1 to 1500
  typedef logic [10:0] length_t;

  typedef struct packed {
    mac_addr_t   dst_mac;
    logic [15:0] ethertype; // High byte sent first
    length_t     length;
  } tx_meta_t;

  typedef struct packed {
    logic       val;
    logic [7:0] dat;
  } phy_byte_t;

endpackage : mac_tx_pkg
